//--- vlog.f
common/trace_pkg.sv
verilog/trace_regs.sv
trace_match/trace_shift_buffer.sv
trace_match/trace_match_rule.sv
trace_match/trace_trigger.sv
verilog/trace_top.sv
tests/tb_trace_top.sv

//--- Bender.yml
package:
  name: trace_match

sources:
  - common/trace_pkg.sv
  - verilog/trace_regs.sv
  - trace_match/trace_shift_buffer.sv
  - trace_match/trace_match_rule.sv
  - trace_match/trace_trigger.sv
  - verilog/trace_top.sv
  - target: test
    files:
      - tests/tb_trace_top.sv

//--- tests/tb_trace_top.sv
/* testbench of the trace matcher
   random beats and register traffic, checked against a reference model */
`default_nettype none

module tb_trace_top import trace_pkg::*; ();

  localparam int TIMEOUT   = 100;
  localparam int COUNT_MAX = 255;

  logic        fe_clk = 1'b0;
  logic        reset;
  axil_req_t   req;
  axil_rsp_t   rsp;
  trace_beat_t beat;
  logic        trig_out;

  integer      seed = 32'hab4d_0628;
  int          errors = 0;
  int          checks = 0;
  int          pulses = 0;

  // reference model state
  logic [BUFFER_BITS-1:0] hist;
  rule_cfg_t              mcfg [MAX_RULES];
  int                     mcount [MAX_RULES];
  logic [7:0]             m_en;
  logic [7:0]             m_ten;
  int                     m_num;
  logic                   m_armed;
  int                     trig_beats;

  trace_top i_dut (
    .fe_clk   (fe_clk),
    .reset    (reset),
    .axil_req (req),
    .axil_rsp (rsp),
    .beat     (beat),
    .trig_out (trig_out)
  );

  always #10 fe_clk = ~fe_clk;

  always @(negedge fe_clk) begin
    if (!reset && trig_out) pulses++;  // one per pulse cycle
  end

  task automatic check(input logic [63:0] got, input logic [63:0] exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERR %0t %s: got %0h expected %0h", $time, what, got, exp);
    end
  endtask

  task automatic abort_on_timeout(input string what);
    $display("timeout while waiting for %s, simulation stopped", what);
    $display("CHECKS FAILED");
    $finish;
  endtask

  task automatic step();
    @(posedge fe_clk);
    #2;
  endtask

  task automatic axil_write(input logic [7:0] addr, input logic [31:0] data);
    int   timer;
    int   hold;
    logic seen;
    req.awaddr  = addr;
    req.awvalid = 1'b1;
    req.wdata   = data;
    req.wvalid  = 1'b1;
    timer = 0;
    seen  = 1'b0;
    while (!seen) begin
      @(negedge fe_clk);
      seen = rsp.awready && rsp.wready;
      step();
      timer++;
      if (!seen && timer > TIMEOUT) abort_on_timeout("write address");
    end
    req.awvalid = 1'b0;
    req.wvalid  = 1'b0;
    hold  = $random(seed) & 3;  // bready back-pressure
    timer = 0;
    seen  = 1'b0;
    while (!seen) begin
      @(negedge fe_clk);
      seen = rsp.bvalid;
      if (!seen) begin
        step();
        timer++;
        if (timer > TIMEOUT) abort_on_timeout("write response");
      end
    end
    check(rsp.bresp, 2'b00, "bresp");
    repeat (hold) begin
      step();
      @(negedge fe_clk);
      check(rsp.bvalid, 1'b1, "bvalid held");
    end
    step();
    req.bready = 1'b1;
    step();
    req.bready = 1'b0;
  endtask

  task automatic axil_read(input logic [7:0] addr, output logic [31:0] data);
    int   timer;
    int   hold;
    logic seen;
    req.araddr  = addr;
    req.arvalid = 1'b1;
    timer = 0;
    seen  = 1'b0;
    while (!seen) begin
      @(negedge fe_clk);
      seen = rsp.arready;
      step();
      timer++;
      if (!seen && timer > TIMEOUT) abort_on_timeout("read address");
    end
    req.arvalid = 1'b0;
    hold  = $random(seed) & 3;
    timer = 0;
    seen  = 1'b0;
    while (!seen) begin
      @(negedge fe_clk);
      seen = rsp.rvalid;
      if (!seen) begin
        step();
        timer++;
        if (timer > TIMEOUT) abort_on_timeout("read data");
      end
    end
    data = rsp.rdata;
    check(rsp.rresp, 2'b00, "rresp");
    repeat (hold) begin
      step();
      @(negedge fe_clk);
      check(rsp.rvalid, 1'b1, "rvalid held");
      check(rsp.rdata, data, "rdata held");
    end
    step();
    req.rready = 1'b1;
    step();
    req.rready = 1'b0;
  endtask

  task automatic read_expect(input logic [7:0] addr, input logic [31:0] exp, input string what);
    logic [31:0] data;
    axil_read(addr, data);
    check(data, exp, $sformatf("%s at %02h", what, addr));
  endtask

  task automatic write_rule(input int r);
    axil_write(8'(16 * r),      mcfg[r].pattern[31:0]);
    axil_write(8'(16 * r + 4),  mcfg[r].pattern[63:32]);
    axil_write(8'(16 * r + 8),  mcfg[r].mask[31:0]);
    axil_write(8'(16 * r + 12), mcfg[r].mask[63:32]);
  endtask

  // short masks look only at bits 1..0 of each nibble
  task automatic program_rules(input logic short_mask);
    int w;
    for (int r = 0; r < MAX_RULES; r++) begin
      mcfg[r].pattern = {$random(seed), $random(seed)};
      if (short_mask) begin
        w = 8 + (($random(seed) & 32'h7fff_ffff) % 9);
        mcfg[r].mask = ((64'd1 << w) - 1) & 64'h3333_3333_3333_3333;
      end else begin
        mcfg[r].mask = {$random(seed), $random(seed)};
      end
      write_rule(r);
    end
  endtask

  task automatic verify_rules();
    for (int r = 0; r < MAX_RULES; r++) begin
      read_expect(8'(16 * r),      mcfg[r].pattern[31:0],  "pattern low");
      read_expect(8'(16 * r + 4),  mcfg[r].pattern[63:32], "pattern high");
      read_expect(8'(16 * r + 8),  mcfg[r].mask[31:0],     "mask low");
      read_expect(8'(16 * r + 12), mcfg[r].mask[63:32],    "mask high");
    end
  endtask

  task automatic write_ctrl();
    axil_write(REG_CTRL, {16'h0, m_ten, m_en});
  endtask

  task automatic clear_counts();
    axil_write(REG_CLEAR, 32'h0);
    for (int r = 0; r < MAX_RULES; r++) mcount[r] = 0;
  endtask

  task automatic model_beat(input logic [3:0] nib);
    logic [7:0] hv;
    hist = {hist[BUFFER_BITS-NIBBLE_BITS-1:0], nib};
    hv   = '0;
    for (int r = 0; r < MAX_RULES; r++) begin
      if (m_en[r] && mcfg[r].mask != '0 &&
          ((hist ^ mcfg[r].pattern) & mcfg[r].mask) == '0) begin
        hv[r] = 1'b1;
        if (mcount[r] < COUNT_MAX) mcount[r]++;
      end
    end
    if (m_armed && (hv & m_ten) != '0) trig_beats++;
  endtask

  task automatic drive_beats(input int n, input logic gaps, input logic [3:0] nib_mask);
    trace_beat_t b;
    for (int i = 0; i < n; i++) begin
      b.valid  = gaps ? (($random(seed) & 3) != 0) : 1'b1;
      b.nibble = $random(seed) & nib_mask;
      step();
      beat = b;
      if (b.valid) model_beat(b.nibble);
    end
    step();
    beat = '0;
    repeat (4) step();  // let hits and trig_out drain
  endtask

  task automatic check_counts();
    for (int r = 0; r < MAX_RULES; r++) begin
      read_expect(8'(8'h90 + 4 * r), mcount[r], "hit count");
    end
  endtask

  function automatic int expected_pulses();
    return (trig_beats < m_num) ? trig_beats : m_num;
  endfunction

  initial begin
    int p0;
    logic exp_armed;
    reset = 1'b1;
    req   = '0;
    beat  = '0;
    hist  = '0;
    m_en  = '0;
    m_ten = '0;
    m_num = 0;
    m_armed    = 1'b0;
    trig_beats = 0;
    for (int r = 0; r < MAX_RULES; r++) begin
      mcfg[r]   = '0;
      mcount[r] = 0;
    end
    repeat (10) step();
    reset = 1'b0;

    // reset values
    @(negedge fe_clk);
    check(trig_out, 1'b0, "trig_out after reset");
    step();
    verify_rules();
    read_expect(REG_CTRL, 32'h0, "ctrl after reset");
    read_expect(REG_NUM_TRIG, 32'h0, "num_trig after reset");
    read_expect(REG_STATUS, 32'h0, "status after reset");
    check_counts();

    // register readback and unmapped space
    program_rules(1'b0);
    verify_rules();
    read_expect(REG_ARM, 32'h0, "write-only arm");
    read_expect(REG_CLEAR, 32'h0, "write-only clear");
    read_expect(8'hB4, 32'h0, "unmapped");
    read_expect(8'hC8, 32'h0, "unmapped");
    read_expect(8'hFC, 32'h0, "unmapped");

    // random beats against the model
    program_rules(1'b1);
    m_en = $random(seed) | 8'h01;
    write_ctrl();
    drive_beats(2000, 1'b1, 4'h3);
    check_counts();

    // saturation, with one zero mask and one disabled rule
    clear_counts();
    mcfg[0].pattern = '0;
    mcfg[0].mask    = 64'hFF;
    mcfg[1].mask    = '0;
    write_rule(0);
    write_rule(1);
    m_en = 8'hFB;
    write_ctrl();
    drive_beats(300, 1'b0, 4'h0);
    check_counts();
    read_expect(8'h90, COUNT_MAX, "saturated count");

    // armed trigger run
    program_rules(1'b1);
    m_en  = $random(seed) | 8'h01;
    m_ten = $random(seed) | 8'h01;
    m_num = $random(seed) & 15;
    write_ctrl();
    axil_write(REG_NUM_TRIG, m_num);
    p0 = pulses;
    axil_write(REG_ARM, 32'h1);
    m_armed    = 1'b1;
    trig_beats = 0;
    drive_beats(1000, 1'b1, 4'h3);
    check(pulses - p0, expected_pulses(), "trig_out pulses");
    exp_armed = !(m_num != 0 && expected_pulses() == m_num);
    read_expect(REG_STATUS, {23'h0, exp_armed, 4'h0, 4'(expected_pulses())}, "status");
    check_counts();

    // clear, then re-arm with room for pulses, disarm and keep matching
    clear_counts();
    check_counts();
    m_ten = 8'hFF;
    m_num = 15;
    write_ctrl();
    axil_write(REG_NUM_TRIG, m_num);
    axil_write(REG_ARM, 32'h1);
    trig_beats = 0;
    read_expect(REG_STATUS, 32'h100, "status after re-arm");
    axil_write(REG_ARM, 32'h0);
    m_armed = 1'b0;
    p0 = pulses;
    drive_beats(500, 1'b1, 4'h3);
    check(pulses - p0, 0, "pulses after disarm");
    read_expect(REG_STATUS, {28'h0, 4'(expected_pulses())}, "status after disarm");
    check_counts();

    $display("checks: %0d errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- verilog/trace_top.sv
/* trace matcher top level
   register port, history buffer, generated match rules and trigger unit */
`default_nettype none

module trace_top import trace_pkg::*; #(
  parameter int NUM_RULES       = 8,
  parameter int COUNT_BITS      = 8,
  parameter int TRIG_COUNT_BITS = 4
) (
  input  wire          fe_clk,
  input  wire          reset,
  input  axil_req_t    axil_req,
  output axil_rsp_t    axil_rsp,
  input  trace_beat_t  beat,
  output logic         trig_out
);

  rule_cfg_t                  rule_cfg [NUM_RULES];
  logic [COUNT_BITS-1:0]      rule_count [NUM_RULES];
  logic [NUM_RULES-1:0]       rule_enable;
  logic [NUM_RULES-1:0]       trig_enable;
  logic [NUM_RULES-1:0]       hits;
  logic [TRIG_COUNT_BITS-1:0] num_triggers;
  logic [TRIG_COUNT_BITS-1:0] triggers_generated;
  logic                       arm_set;
  logic                       disarm;
  logic                       clear_counts;
  logic                       armed;
  logic [BUFFER_BITS-1:0]     buffer;
  logic                       shifted;

  trace_regs #(
    .NUM_RULES          (NUM_RULES),
    .COUNT_BITS         (COUNT_BITS),
    .TRIG_COUNT_BITS    (TRIG_COUNT_BITS)
  ) i_regs (
    .fe_clk             (fe_clk),
    .reset              (reset),
    .axil_req           (axil_req),
    .axil_rsp           (axil_rsp),
    .rule_cfg           (rule_cfg),
    .rule_enable        (rule_enable),
    .trig_enable        (trig_enable),
    .num_triggers       (num_triggers),
    .arm_set            (arm_set),
    .disarm             (disarm),
    .clear_counts       (clear_counts),
    .rule_count         (rule_count),
    .triggers_generated (triggers_generated),
    .armed              (armed)
  );

  trace_shift_buffer i_buffer (
    .fe_clk  (fe_clk),
    .reset   (reset),
    .beat    (beat),
    .buffer  (buffer),
    .shifted (shifted)
  );

  for (genvar i = 0; i < NUM_RULES; i++) begin : gen_rule
    trace_match_rule #(
      .COUNT_BITS   (COUNT_BITS)
    ) i_rule (
      .fe_clk       (fe_clk),
      .reset        (reset),
      .buffer       (buffer),
      .shifted      (shifted),
      .cfg          (rule_cfg[i]),
      .enable       (rule_enable[i]),
      .clear_counts (clear_counts),
      .hit          (hits[i]),
      .count        (rule_count[i])
    );
  end

  trace_trigger #(
    .NUM_RULES          (NUM_RULES),
    .TRIG_COUNT_BITS    (TRIG_COUNT_BITS)
  ) i_trigger (
    .fe_clk             (fe_clk),
    .reset              (reset),
    .hits               (hits),
    .trig_enable        (trig_enable),
    .num_triggers       (num_triggers),
    .arm_set            (arm_set),
    .disarm             (disarm),
    .trig_out           (trig_out),
    .triggers_generated (triggers_generated),
    .armed              (armed)
  );

endmodule

`default_nettype wire

//--- trace_match/trace_trigger.sv
/* trigger unit
   while armed, turns trigger-enabled rule hits into single pulses up to a limit */
`default_nettype none

module trace_trigger import trace_pkg::*; #(
  parameter int NUM_RULES       = 8,
  parameter int TRIG_COUNT_BITS = 4
) (
  input  wire                         fe_clk,
  input  wire                         reset,
  input  wire [NUM_RULES-1:0]         hits,
  input  wire [NUM_RULES-1:0]         trig_enable,
  input  wire [TRIG_COUNT_BITS-1:0]   num_triggers,
  input  wire                         arm_set,
  input  wire                         disarm,
  output logic                        trig_out,
  output logic [TRIG_COUNT_BITS-1:0]  triggers_generated,
  output logic                        armed
);

  trig_state_e state;
  logic        fire;

  // limit of zero keeps fire low
  assign fire  = (state == TRIG_ARMED) && (|(hits & trig_enable)) &&
                 (triggers_generated < num_triggers);
  assign armed = (state == TRIG_ARMED);

  always_ff @(posedge fe_clk) begin
    if (reset) begin
      state              <= TRIG_IDLE;
      triggers_generated <= '0;
      trig_out           <= 1'b0;
    end else begin
      trig_out <= fire;
      if (arm_set) begin
        state              <= TRIG_ARMED;  // re-arm from anywhere
        triggers_generated <= '0;
      end else if (disarm) begin
        state <= TRIG_IDLE;
      end else if (fire) begin
        triggers_generated <= triggers_generated + 1'b1;
        if (triggers_generated + 1'b1 == num_triggers) begin
          state <= TRIG_DONE;
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- trace_match/trace_match_rule.sv
/* single match rule
   masked compare of the history buffer against a pattern, with saturating hit count */
`default_nettype none

module trace_match_rule import trace_pkg::*; #(
  parameter int COUNT_BITS = 8
) (
  input  wire                     fe_clk,
  input  wire                     reset,
  input  wire [BUFFER_BITS-1:0]   buffer,
  input  wire                     shifted,
  input  rule_cfg_t               cfg,
  input  wire                     enable,
  input  wire                     clear_counts,
  output logic                    hit,
  output logic [COUNT_BITS-1:0]   count
);

  logic match;

  // an all-zero mask never matches
  assign match = enable && (|cfg.mask) && (((buffer ^ cfg.pattern) & cfg.mask) == '0);

  always_ff @(posedge fe_clk) begin
    if (reset) begin
      hit <= 1'b0;
    end else begin
      hit <= shifted && match;
    end
  end

  always_ff @(posedge fe_clk) begin
    if (reset || clear_counts) begin
      count <= '0;
    end else if (shifted && match && count != '1) begin
      count <= count + 1'b1;  // sticks at max
    end
  end

endmodule

`default_nettype wire

//--- trace_match/trace_shift_buffer.sv
/* trace history buffer
   shifts one nibble in per valid beat, newest in the low bits */
`default_nettype none

module trace_shift_buffer import trace_pkg::*; (
  input  wire                     fe_clk,
  input  wire                     reset,
  input  trace_beat_t             beat,
  output logic [BUFFER_BITS-1:0]  buffer,
  output logic                    shifted
);

  always_ff @(posedge fe_clk) begin
    if (reset) begin
      buffer <= '0;
    end else if (beat.valid) begin
      buffer <= {buffer[BUFFER_BITS-NIBBLE_BITS-1:0], beat.nibble};
    end
  end

  // rules look at the buffer only on the cycle after a shift
  always_ff @(posedge fe_clk) begin
    if (reset) begin
      shifted <= 1'b0;
    end else begin
      shifted <= beat.valid;
    end
  end

endmodule

`default_nettype wire

//--- verilog/trace_regs.sv
/* AXI4-Lite register file of the trace matcher
   holds rule patterns and masks, trigger control, reads back counts and status */
`default_nettype none

module trace_regs import trace_pkg::*; #(
  parameter int NUM_RULES       = 8,
  parameter int COUNT_BITS      = 8,
  parameter int TRIG_COUNT_BITS = 4
) (
  input  wire                         fe_clk,
  input  wire                         reset,
  input  axil_req_t                   axil_req,
  output axil_rsp_t                   axil_rsp,
  output rule_cfg_t                   rule_cfg [NUM_RULES],
  output logic [NUM_RULES-1:0]        rule_enable,
  output logic [NUM_RULES-1:0]        trig_enable,
  output logic [TRIG_COUNT_BITS-1:0]  num_triggers,
  output logic                        arm_set,
  output logic                        disarm,
  output logic                        clear_counts,
  input  wire [COUNT_BITS-1:0]        rule_count [NUM_RULES],
  input  wire [TRIG_COUNT_BITS-1:0]   triggers_generated,
  input  wire                         armed
);

  logic                      wr_accept;
  logic                      rd_accept;
  logic                      bvalid_q;
  logic                      rvalid_q;
  logic [AXIL_DATA_BITS-1:0] rdata_q;
  logic [AXIL_DATA_BITS-1:0] rdata_next;
  reg_sel_e                  wsel;
  reg_sel_e                  rsel;
  logic [2:0]                widx;
  logic [2:0]                ridx;
  logic [2:0]                cidx;
  logic [AXIL_ADDR_BITS-1:0] cnt_off;

  assign wr_accept = axil_req.awvalid && axil_req.wvalid && !bvalid_q;
  assign rd_accept = axil_req.arvalid && !rvalid_q;

  assign wsel    = reg_sel_e'(axil_req.awaddr);
  assign rsel    = reg_sel_e'(axil_req.araddr);
  assign widx    = axil_req.awaddr[6:4];  // 16 bytes per rule
  assign ridx    = axil_req.araddr[6:4];
  assign cnt_off = axil_req.araddr - 8'h90;
  assign cidx    = cnt_off[4:2];

  assign axil_rsp.awready = wr_accept;
  assign axil_rsp.wready  = wr_accept;
  assign axil_rsp.bvalid  = bvalid_q;
  assign axil_rsp.bresp   = 2'b00;
  assign axil_rsp.arready = !rvalid_q;
  assign axil_rsp.rdata   = rdata_q;
  assign axil_rsp.rresp   = 2'b00;
  assign axil_rsp.rvalid  = rvalid_q;

  // configuration writes
  always_ff @(posedge fe_clk) begin
    if (reset) begin
      for (int r = 0; r < NUM_RULES; r++) begin
        rule_cfg[r] <= '0;
      end
      rule_enable  <= '0;
      trig_enable  <= '0;
      num_triggers <= '0;
    end else if (wr_accept) begin
      if (!axil_req.awaddr[7]) begin
        if (int'(widx) < NUM_RULES) begin
          case (axil_req.awaddr[3:2])
            2'd0: rule_cfg[widx].pattern[31:0]  <= axil_req.wdata;
            2'd1: rule_cfg[widx].pattern[63:32] <= axil_req.wdata;
            2'd2: rule_cfg[widx].mask[31:0]     <= axil_req.wdata;
            2'd3: rule_cfg[widx].mask[63:32]    <= axil_req.wdata;
          endcase
        end
      end else begin
        case (wsel)
          REG_CTRL: begin
            rule_enable <= axil_req.wdata[NUM_RULES-1:0];
            trig_enable <= axil_req.wdata[8 +: NUM_RULES];
          end
          REG_NUM_TRIG: num_triggers <= axil_req.wdata[TRIG_COUNT_BITS-1:0];
          default: ;  // read-only or unmapped
        endcase
      end
    end
  end

  // one-cycle command pulses
  always_ff @(posedge fe_clk) begin
    if (reset) begin
      arm_set      <= 1'b0;
      disarm       <= 1'b0;
      clear_counts <= 1'b0;
    end else begin
      arm_set      <= wr_accept && wsel == REG_ARM && axil_req.wdata[0];
      disarm       <= wr_accept && wsel == REG_ARM && !axil_req.wdata[0];
      clear_counts <= wr_accept && wsel == REG_CLEAR;
    end
  end

  // write response
  always_ff @(posedge fe_clk) begin
    if (reset) begin
      bvalid_q <= 1'b0;
    end else if (wr_accept) begin
      bvalid_q <= 1'b1;
    end else if (axil_req.bready) begin
      bvalid_q <= 1'b0;
    end
  end

  always_comb begin
    rdata_next = '0;
    if (!axil_req.araddr[7]) begin
      if (int'(ridx) < NUM_RULES) begin
        case (axil_req.araddr[3:2])
          2'd0: rdata_next = rule_cfg[ridx].pattern[31:0];
          2'd1: rdata_next = rule_cfg[ridx].pattern[63:32];
          2'd2: rdata_next = rule_cfg[ridx].mask[31:0];
          2'd3: rdata_next = rule_cfg[ridx].mask[63:32];
        endcase
      end
    end else if (axil_req.araddr >= 8'h90 && axil_req.araddr <= 8'hAC) begin
      if (int'(cidx) < NUM_RULES) begin
        rdata_next[COUNT_BITS-1:0] = rule_count[cidx];  // hit counters
      end
    end else begin
      case (rsel)
        REG_CTRL: begin
          rdata_next[NUM_RULES-1:0]  = rule_enable;
          rdata_next[8 +: NUM_RULES] = trig_enable;
        end
        REG_NUM_TRIG: rdata_next[TRIG_COUNT_BITS-1:0] = num_triggers;
        REG_STATUS: begin
          rdata_next[TRIG_COUNT_BITS-1:0] = triggers_generated;
          rdata_next[8]                   = armed;
        end
        default: ;
      endcase
    end
  end

  // read response held until rready
  always_ff @(posedge fe_clk) begin
    if (reset) begin
      rvalid_q <= 1'b0;
    end else if (rd_accept) begin
      rvalid_q <= 1'b1;
    end else if (axil_req.rready) begin
      rvalid_q <= 1'b0;
    end
  end

  always_ff @(posedge fe_clk) begin
    if (rd_accept) begin
      rdata_q <= rdata_next;
    end
  end

endmodule

`default_nettype wire

//--- common/trace_pkg.sv
/* trace matcher shared definitions
   bus widths, register map, beat and rule types */
`default_nettype none

package trace_pkg;

  localparam int BUFFER_BITS    = 64;
  localparam int NIBBLE_BITS    = 4;
  localparam int MAX_RULES      = 8;
  localparam int AXIL_ADDR_BITS = 8;
  localparam int AXIL_DATA_BITS = 32;

  typedef struct packed {
    logic                   valid;
    logic [NIBBLE_BITS-1:0] nibble;
  } trace_beat_t;

  typedef struct packed {
    logic [BUFFER_BITS-1:0] pattern;
    logic [BUFFER_BITS-1:0] mask;  // 1 = compare this bit
  } rule_cfg_t;

  // manager side of the register bus
  typedef struct packed {
    logic [AXIL_ADDR_BITS-1:0] awaddr;
    logic                      awvalid;
    logic [AXIL_DATA_BITS-1:0] wdata;
    logic                      wvalid;
    logic                      bready;
    logic [AXIL_ADDR_BITS-1:0] araddr;
    logic                      arvalid;
    logic                      rready;
  } axil_req_t;

  typedef struct packed {
    logic                      awready;
    logic                      wready;
    logic                      bvalid;
    logic [1:0]                bresp;
    logic                      arready;
    logic [AXIL_DATA_BITS-1:0] rdata;
    logic [1:0]                rresp;
    logic                      rvalid;
  } axil_rsp_t;

  // fixed control offsets, rule words live below 0x80
  typedef enum logic [AXIL_ADDR_BITS-1:0] {
    REG_CTRL     = 8'h80,
    REG_NUM_TRIG = 8'h84,
    REG_ARM      = 8'h88,
    REG_STATUS   = 8'h8C,
    REG_CLEAR    = 8'hB0
  } reg_sel_e;

  typedef enum logic [1:0] {
    TRIG_IDLE,
    TRIG_ARMED,
    TRIG_DONE
  } trig_state_e;

endpackage

`default_nettype wire
